/* backend_top.sv */
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module backend_top
import uop_pkg::*;
import rs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Rename side
    input  logic        prv_valid,
    output logic        prv_ready,
    input  logic        uops_valid [`ID_WIDTH],
    input  uop_t        uops       [`ID_WIDTH],

    // Execution side
    output logic        issue_valid,
    input  logic        issue_ready,
    output rs_class_t   issue_class,
    output alu_uop_t    issue_alu,
    output mem_uop_t    issue_mem,

    output perf_count_t perf_alu_dispatched,
    output perf_count_t perf_mem_dispatched
);

    //////////////////////////////
    // Dispatch to queues
    //////////////////////////////

    logic       alu_wr_valid [`ID_WIDTH];
    alu_uop_t   alu_wr_data  [`ID_WIDTH];
    seq_t       alu_wr_seq   [`ID_WIDTH];
    logic       mem_wr_valid;
    mem_uop_t   mem_wr_data;
    seq_t       mem_wr_seq;
    logic       alu_credit_return;
    logic       mem_credit_return;

    // Single-port memory queue takes one-entry arrays
    logic       mem_wr_valid_arr [1];
    mem_uop_t   mem_wr_data_arr  [1];
    seq_t       mem_wr_seq_arr   [1];

    assign mem_wr_valid_arr[0] = mem_wr_valid;
    assign mem_wr_data_arr[0]  = mem_wr_data;
    assign mem_wr_seq_arr[0]   = mem_wr_seq;

    //////////////////////////////
    // Queues to merger
    //////////////////////////////

    logic       alu_head_valid;
    alu_uop_t   alu_head_data;
    seq_t       alu_head_seq;
    logic       alu_pop;
    logic       mem_head_valid;
    mem_uop_t   mem_head_data;
    seq_t       mem_head_seq;
    logic       mem_pop;

    dispatch_stage dispatch (
        .clk, .rst,
        .prv_valid, .prv_ready, .uops_valid, .uops,
        .alu_wr_valid, .alu_wr_data, .alu_wr_seq, .alu_credit_return,
        .mem_wr_valid, .mem_wr_data, .mem_wr_seq, .mem_credit_return,
        .perf_alu_dispatched, .perf_mem_dispatched
    );

    rs_queue #(.payload_t(alu_uop_t), .DEPTH(`ALU_RS_DEPTH), .WR_PORTS(`ID_WIDTH)) alu_rs (
        .clk, .rst,
        .wr_valid(alu_wr_valid), .wr_data(alu_wr_data), .wr_seq(alu_wr_seq),
        .head_valid(alu_head_valid), .head_data(alu_head_data), .head_seq(alu_head_seq),
        .pop(alu_pop), .credit_return(alu_credit_return)
    );

    rs_queue #(.payload_t(mem_uop_t), .DEPTH(`MEM_RS_DEPTH), .WR_PORTS(1)) mem_rs (
        .clk, .rst,
        .wr_valid(mem_wr_valid_arr), .wr_data(mem_wr_data_arr), .wr_seq(mem_wr_seq_arr),
        .head_valid(mem_head_valid), .head_data(mem_head_data), .head_seq(mem_head_seq),
        .pop(mem_pop), .credit_return(mem_credit_return)
    );

    issue_merge merge (
        .alu_head_valid, .alu_head_data, .alu_head_seq, .alu_pop,
        .mem_head_valid, .mem_head_data, .mem_head_seq, .mem_pop,
        .issue_valid, .issue_ready, .issue_class, .issue_alu, .issue_mem
    );

endmodule

/* dispatch_settings.svh */
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

//////////////////////////////
// Front-end bundle
//////////////////////////////

`define ID_WIDTH 2            // Micro-ops per rename bundle

//////////////////////////////
// Reservation queues
//////////////////////////////

`define ALU_RS_DEPTH 4        // Also the ALU credit count after reset
`define MEM_RS_DEPTH 4        // Also the memory credit count after reset

//////////////////////////////
// Tags
//////////////////////////////

// Age stamp width, must cover well over twice the entries in flight
`define SEQ_BITS 6
`define REG_BITS 6            // Physical register tag

`endif

/* dispatch_stage.sv */
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module dispatch_stage
import uop_pkg::*;
import rs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Rename handshake
    input  logic        prv_valid,
    output logic        prv_ready,
    input  logic        uops_valid   [`ID_WIDTH],
    input  uop_t        uops         [`ID_WIDTH],

    // ALU queue
    output logic        alu_wr_valid [`ID_WIDTH],
    output alu_uop_t    alu_wr_data  [`ID_WIDTH],
    output seq_t        alu_wr_seq   [`ID_WIDTH],
    input  logic        alu_credit_return,

    // Memory queue
    output logic        mem_wr_valid,
    output mem_uop_t    mem_wr_data,
    output seq_t        mem_wr_seq,
    input  logic        mem_credit_return,

    output perf_count_t perf_alu_dispatched,
    output perf_count_t perf_mem_dispatched
);

    credit_t    alu_credits;
    credit_t    mem_credits;
    credit_t    alu_cnt;
    credit_t    mem_cnt;
    credit_t    alu_used;
    credit_t    mem_used;
    logic       bad_slot;
    logic       accept;
    seq_t       seq_ctr;                        // Stamp of the next accepted micro-op
    logic       alu_pack_valid [`ID_WIDTH];
    logic       mem_pack_valid;

    //////////////////////////////
    // Bundle check
    //////////////////////////////

    always_comb begin
        alu_cnt  = '0;
        mem_cnt  = '0;
        bad_slot = 1'b0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (uops_valid[i]) begin
                case (uops[i].rs_class)
                    RS_ALU:  alu_cnt = alu_cnt + credit_t'(1);
                    RS_MEM:  mem_cnt = mem_cnt + credit_t'(1);
                    default: bad_slot = 1'b1;   // No station for this slot
                endcase
            end
        end
    end

    // Only one memory write port, so at most one memory slot per bundle
    assign prv_ready = !bad_slot
                    && (alu_cnt <= alu_credits)
                    && (mem_cnt <= mem_credits)
                    && (mem_cnt <= credit_t'(1));

    assign accept = prv_valid && prv_ready;

    //////////////////////////////
    // Routing and packing
    //////////////////////////////

    always_comb begin
        int   alu_pos;
        seq_t seq_ofs;
        alu_pos = 0;
        seq_ofs = '0;
        for (int k = 0; k < `ID_WIDTH; k++) begin
            alu_pack_valid[k] = 1'b0;
            alu_wr_data[k]    = '0;
            alu_wr_seq[k]     = '0;
        end
        mem_pack_valid = 1'b0;
        mem_wr_data    = '0;
        mem_wr_seq     = '0;
        for (int i = 0; i < `ID_WIDTH; i++) begin
            if (uops_valid[i]) begin
                if (uops[i].rs_class == RS_ALU) begin
                    alu_pack_valid[alu_pos] = 1'b1;     // Lower slot takes lower port
                    alu_wr_data[alu_pos]    = uops[i].alu;
                    alu_wr_seq[alu_pos]     = seq_ctr + seq_ofs;
                    alu_pos                 = alu_pos + 1;
                end else if (uops[i].rs_class == RS_MEM && !mem_pack_valid) begin
                    mem_pack_valid = 1'b1;
                    mem_wr_data    = uops[i].mem;
                    mem_wr_seq     = seq_ctr + seq_ofs;
                end
                seq_ofs = seq_ofs + seq_t'(1);  // One stamp per valid slot
            end
        end
    end

    for (genvar k = 0; k < `ID_WIDTH; k++) begin : g_alu_wr
        assign alu_wr_valid[k] = accept && alu_pack_valid[k];
    end

    assign mem_wr_valid = accept && mem_pack_valid;

    //////////////////////////////
    // Credits, stamps, counters
    //////////////////////////////

    assign alu_used = accept ? alu_cnt : '0;
    assign mem_used = accept ? mem_cnt : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_credits         <= credit_t'(`ALU_RS_DEPTH);
            mem_credits         <= credit_t'(`MEM_RS_DEPTH);
            seq_ctr             <= '0;
            perf_alu_dispatched <= '0;
            perf_mem_dispatched <= '0;
        end else begin
            // Spend and refund in the same cycle
            alu_credits <= alu_credits - alu_used + credit_t'(alu_credit_return);
            mem_credits <= mem_credits - mem_used + credit_t'(mem_credit_return);
            if (accept) begin
                seq_ctr             <= seq_ctr + seq_t'(alu_cnt + mem_cnt);
                perf_alu_dispatched <= perf_alu_dispatched + perf_count_t'(alu_cnt);
                perf_mem_dispatched <= perf_mem_dispatched + perf_count_t'(mem_cnt);
            end
        end
    end

endmodule

/* dispatch_tests.txt */
# Per slot: valid class(1=ALU 2=MEM) and five hex fields, slot 0 then slot 1
# ALU fields: op dst src1 src2 imm   MEM fields: store size dst base offset
1 1 3 01 02 03 a5    1 1 7 04 05 06 3c
1 1 2 07 08 09 11    1 2 0 2 0a 0b 0123
1 2 1 3 00 0c 3fff   1 1 f 0d 0e 0f ff
1 1 4 10 11 12 00    0 0 0 00 00 00 00
0 0 0 00 00 00 00    1 2 0 1 13 14 0040
1 2 1 0 00 15 1abc   0 0 0 00 00 00 00
0 0 0 00 00 00 00    1 1 9 17 18 19 7e
1 1 a 1a 1b 1c 80    1 1 b 1d 1e 1f 01
1 2 0 3 20 21 2000   1 1 c 22 23 24 c3
1 1 d 25 26 27 5a    1 2 1 2 00 28 0fff
1 2 0 0 29 2a 0001   0 0 0 00 00 00 00
1 2 1 1 00 2b 3ffe   0 0 0 00 00 00 00
1 2 0 2 2c 2d 1234   1 1 e 2e 2f 30 99
1 1 0 31 32 33 00    1 1 1 34 35 36 ff
1 1 5 37 38 39 42    1 1 6 3a 3b 3c 24
0 0 0 00 00 00 00    1 1 8 3d 3e 3f 10
1 2 0 3 01 02 0555   0 0 0 00 00 00 00
1 1 2 03 04 05 e7    1 2 1 0 00 06 2aaa
1 1 3 07 08 09 18    0 0 0 00 00 00 00
0 0 0 00 00 00 00    1 2 0 1 0a 0b 0777
1 1 4 0c 0d 0e 6d    1 1 5 0f 10 11 b2
1 2 1 3 00 12 1f1f   1 1 7 13 14 15 3b
1 1 9 16 17 18 c0    1 2 0 2 19 1a 0a0a
1 1 f 1b 1c 1d 0f    1 1 e 1e 1f 20 f0

/* files.f */
+incdir+.
uop_pkg.sv
rs_pkg.sv
dispatch_stage.sv
rs_queue.sv
issue_merge.sv
backend_top.sv
tb_clock_gen.sv
tb_backend.sv

/* issue_merge.sv */
`timescale 1ns/100ps

module issue_merge
import uop_pkg::*;
import rs_pkg::*;
(
    // ALU queue head
    input  logic        alu_head_valid,
    input  alu_uop_t    alu_head_data,
    input  seq_t        alu_head_seq,
    output logic        alu_pop,

    // Memory queue head
    input  logic        mem_head_valid,
    input  mem_uop_t    mem_head_data,
    input  seq_t        mem_head_seq,
    output logic        mem_pop,

    // Issue port
    output logic        issue_valid,
    input  logic        issue_ready,
    output rs_class_t   issue_class,
    output alu_uop_t    issue_alu,
    output mem_uop_t    issue_mem
);

    seq_t       seq_diff;
    logic       alu_older;
    logic       pick_alu;
    logic       pick_mem;

    // Negative difference means the ALU head was stamped first
    assign seq_diff  = alu_head_seq - mem_head_seq;
    assign alu_older = seq_diff[$bits(seq_t)-1];

    assign pick_alu = alu_head_valid && (!mem_head_valid || alu_older);
    assign pick_mem = mem_head_valid && !pick_alu;

    assign issue_valid = pick_alu || pick_mem;

    always_comb begin
        if (pick_alu) begin
            issue_class = RS_ALU;
        end else if (pick_mem) begin
            issue_class = RS_MEM;
        end else begin
            issue_class = RS_NONE;
        end
    end

    assign issue_alu = alu_head_data;           // Qualified by issue_class
    assign issue_mem = mem_head_data;

    // Pop only on a completed handshake
    assign alu_pop = pick_alu && issue_ready;
    assign mem_pop = pick_mem && issue_ready;

endmodule

/* rs_pkg.sv */
`include "dispatch_settings.svh"

package rs_pkg;

    //////////////////////////////
    // Age stamps
    //////////////////////////////

    // Wraps around, compared by the sign of the difference
    typedef logic [`SEQ_BITS-1:0] seq_t;

    //////////////////////////////
    // Credits
    //////////////////////////////

    localparam int CREDIT_MAX = (`ALU_RS_DEPTH > `MEM_RS_DEPTH) ?
                                `ALU_RS_DEPTH : `MEM_RS_DEPTH;
    localparam int CREDIT_BITS = $clog2(CREDIT_MAX + 1);   // Holds a full queue

    typedef logic [CREDIT_BITS-1:0] credit_t;

    //////////////////////////////
    // Performance counters
    //////////////////////////////

    typedef logic [31:0] perf_count_t;

endpackage

/* rs_queue.sv */
`timescale 1ns/100ps

module rs_queue
import rs_pkg::*;
#(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4,
    parameter int  WR_PORTS  = 1
)
(
    input  logic        clk,
    input  logic        rst,

    // Packed writes from dispatch
    input  logic        wr_valid [WR_PORTS],
    input  payload_t    wr_data  [WR_PORTS],
    input  seq_t        wr_seq   [WR_PORTS],

    // Oldest entry toward the merger
    output logic        head_valid,
    output payload_t    head_data,
    output seq_t        head_seq,
    input  logic        pop,

    output logic        credit_return           // One pulse per issued entry
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    payload_t   entry_data [DEPTH];
    seq_t       entry_seq  [DEPTH];

    ptr_t       head_ptr;
    ptr_t       tail_ptr;
    cnt_t       count;
    ptr_t       wr_slot [WR_PORTS];
    cnt_t       wr_total;
    logic       pop_fire;

    // Circular increment, offset never exceeds one lap
    function automatic ptr_t ptr_add(ptr_t base, cnt_t ofs);
        int sum;
        sum = int'(base) + int'(ofs);
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    // Slot for each write port in port order
    always_comb begin
        cnt_t ofs;
        ofs = '0;
        for (int p = 0; p < WR_PORTS; p++) begin
            wr_slot[p] = ptr_add(tail_ptr, ofs);
            if (wr_valid[p]) begin
                ofs = ofs + cnt_t'(1);
            end
        end
        wr_total = ofs;
    end

    assign head_valid = (count != '0);
    assign head_data  = entry_data[head_ptr];
    assign head_seq   = entry_seq[head_ptr];
    assign pop_fire   = pop && head_valid;

    always_ff @(posedge clk) begin
        for (int p = 0; p < WR_PORTS; p++) begin
            if (wr_valid[p]) begin
                entry_data[wr_slot[p]] <= wr_data[p];
                entry_seq[wr_slot[p]]  <= wr_seq[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr      <= '0;
            tail_ptr      <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            tail_ptr <= ptr_add(tail_ptr, wr_total);
            if (pop_fire) begin
                head_ptr <= ptr_add(head_ptr, cnt_t'(1));
            end
            count         <= count + wr_total - cnt_t'(pop_fire);
            credit_return <= pop_fire;              // Seen by dispatch one edge later
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line appears in the output
verilator --binary --timing -Wno-fatal --top-module tb_backend -f files.f \
    && ./obj_dir/Vtb_backend | tee /dev/stderr \
    | grep -x "Simulation completed successfully" > /dev/null \
    && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

/* tb_backend.sv */
`timescale 1ns/100ps
`include "dispatch_settings.svh"

module tb_backend
import uop_pkg::*;
import rs_pkg::*;
();

    localparam int MAX_BUNDLES = 64;
    localparam int PASSES      = 2;         // Second pass wraps the age stamps

    logic        clk;
    logic        rst;
    logic        prv_valid;
    logic        prv_ready;
    logic        uops_valid [`ID_WIDTH];
    uop_t        uops       [`ID_WIDTH];
    logic        issue_valid;
    logic        issue_ready;
    rs_class_t   issue_class;
    alu_uop_t    issue_alu;
    mem_uop_t    issue_mem;
    perf_count_t perf_alu_dispatched;
    perf_count_t perf_mem_dispatched;

    logic        bun_valid [MAX_BUNDLES][`ID_WIDTH];
    uop_t        bun_uop   [MAX_BUNDLES][`ID_WIDTH];
    int          num_bundles;
    int          cycle_limit;
    int          seed;
    int          value_errs;
    int          other_errs;
    int          acc_idx;                   // Global acceptance index of the next micro-op
    int          n_alu;
    int          n_mem;

    // Expected queues, with acceptance index and edge per entry
    alu_uop_t    alu_exp  [$];
    int          alu_idx  [$];
    int          alu_edge [$];
    mem_uop_t    mem_exp  [$];
    int          mem_idx  [$];
    int          mem_edge [$];

    tb_clock_gen clock_gen (.clk, .rst);

    backend_top uut (
        .clk, .rst,
        .prv_valid, .prv_ready, .uops_valid, .uops,
        .issue_valid, .issue_ready, .issue_class, .issue_alu, .issue_mem,
        .perf_alu_dispatched, .perf_mem_dispatched
    );

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_alu(input string name, input alu_uop_t got, input alu_uop_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mem(input string name, input mem_uop_t got, input mem_uop_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input perf_count_t got,
                               input perf_count_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////
    // Test file
    //////////////////////////////

    // Unused payload field gets random bits, dispatch must ignore it
    function automatic uop_t make_uop(int cls, int a, int b, int c, int d, int e, int junk);
        uop_t u;
        u.alu      = junk[29:0];
        u.mem      = ~junk[29:0];
        u.rs_class = rs_class_t'(cls[1:0]);
        if (cls == 1) begin
            u.alu.op   = a[3:0];
            u.alu.dst  = b[`REG_BITS-1:0];
            u.alu.src1 = c[`REG_BITS-1:0];
            u.alu.src2 = d[`REG_BITS-1:0];
            u.alu.imm  = e[7:0];
        end else if (cls == 2) begin
            u.mem.is_store = a[0];
            u.mem.size     = b[2:0];
            u.mem.dst      = c[`REG_BITS-1:0];
            u.mem.base     = d[`REG_BITS-1:0];
            u.mem.offset   = e[13:0];
        end
        return u;
    endfunction

    task automatic load_tests();
        int    fd;
        int    n;
        int    f [14];
        string line;
        fd = $fopen("dispatch_tests.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Could not open dispatch_tests.txt");
            return;
        end
        while (!$feof(fd) && num_bundles < MAX_BUNDLES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (n != 14) begin
                other_errs++;
                $display("Malformed line in dispatch_tests.txt: %s", line);
                continue;
            end
            for (int s = 0; s < `ID_WIDTH; s++) begin
                bun_valid[num_bundles][s] = f[7*s][0];
                bun_uop[num_bundles][s]   = make_uop(f[7*s+1], f[7*s+2], f[7*s+3],
                                                     f[7*s+4], f[7*s+5], f[7*s+6],
                                                     $random(seed));
            end
            num_bundles++;
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    task automatic push_bundle(input int b, input int edge_no);
        for (int s = 0; s < `ID_WIDTH; s++) begin
            if (bun_valid[b][s] && bun_uop[b][s].rs_class == RS_ALU) begin
                alu_exp.push_back(bun_uop[b][s].alu);
                alu_idx.push_back(acc_idx);
                alu_edge.push_back(edge_no);
                n_alu++;
            end else if (bun_valid[b][s] && bun_uop[b][s].rs_class == RS_MEM) begin
                mem_exp.push_back(bun_uop[b][s].mem);
                mem_idx.push_back(acc_idx);
                mem_edge.push_back(edge_no);
                n_mem++;
            end
            if (bun_valid[b][s]) begin
                acc_idx++;
            end
        end
    endtask

    // Other class head must not be older if it sat in its queue long enough
    task automatic check_issue(input int edge_no);
        if (issue_class == RS_ALU && alu_exp.size() != 0) begin
            check_alu("issue_alu", issue_alu, alu_exp[0]);
            if (mem_idx.size() != 0 && mem_edge[0] <= edge_no - 2 && alu_idx[0] > mem_idx[0]) begin
                other_errs++;
                $display("ALU micro-op %0d issued ahead of older memory micro-op %0d",
                         alu_idx[0], mem_idx[0]);
            end
            void'(alu_exp.pop_front());
            void'(alu_idx.pop_front());
            void'(alu_edge.pop_front());
        end else if (issue_class == RS_MEM && mem_exp.size() != 0) begin
            check_mem("issue_mem", issue_mem, mem_exp[0]);
            if (alu_idx.size() != 0 && alu_edge[0] <= edge_no - 2 && mem_idx[0] > alu_idx[0]) begin
                other_errs++;
                $display("Memory micro-op %0d issued ahead of older ALU micro-op %0d",
                         mem_idx[0], alu_idx[0]);
            end
            void'(mem_exp.pop_front());
            void'(mem_idx.pop_front());
            void'(mem_edge.pop_front());
        end else begin
            other_errs++;
            $display("Unexpected issue of class %0d with nothing outstanding for it",
                     issue_class);
        end
    endtask

    //////////////////////////////
    // Stimulus and checks
    //////////////////////////////

    initial begin : stimulus
        int bi;
        int total;
        int cur_b;
        int idle;
        int cyc;
        bit holding;
        bit acc;
        bit first_pending;
        bit saw_drop;
        bit finished;
        seed        = 83185;
        value_errs  = 0;
        other_errs  = 0;
        acc_idx     = 0;
        n_alu       = 0;
        n_mem       = 0;
        num_bundles = 0;
        prv_valid   = 1'b0;
        issue_ready = 1'b0;
        for (int s = 0; s < `ID_WIDTH; s++) begin
            uops_valid[s] = 1'b0;
            uops[s]       = '0;
        end
        load_tests();
        total       = num_bundles * PASSES;
        cycle_limit = 40 * total + 200;
        bi = 0;
        cur_b = 0;
        idle = 0;
        cyc = 0;
        holding = 1'b0;
        acc = 1'b0;
        first_pending = 1'b1;
        saw_drop = 1'b0;
        finished = 1'b0;

        do begin
            @(negedge clk);
        end while (rst);
        if (issue_valid !== 1'b0) begin
            other_errs++;
            $display("issue_valid is high right after reset");
        end
        check_count("perf_alu_dispatched", perf_alu_dispatched, '0);
        check_count("perf_mem_dispatched", perf_mem_dispatched, '0);

        while (!finished) begin
            @(posedge clk);
            cyc++;
            if (acc) begin
                prv_valid <= 1'b0;
                for (int s = 0; s < `ID_WIDTH; s++) begin
                    uops_valid[s] <= 1'b0;
                end
                holding = 1'b0;
                idle    = {$random(seed)} % 3;
            end
            if (!holding && bi < total) begin
                if (idle == 0) begin
                    cur_b = bi % num_bundles;
                    for (int s = 0; s < `ID_WIDTH; s++) begin
                        uops_valid[s] <= bun_valid[cur_b][s];
                        uops[s]       <= bun_uop[cur_b][s];
                    end
                    prv_valid <= 1'b1;
                    holding = 1'b1;
                    bi++;
                end else begin
                    idle--;
                end
            end
            // Last 30 of every 100 cycles the execution side stalls
            issue_ready <= ((cyc % 100) < 70) && (({$random(seed)} % 10) < 6);

            @(negedge clk);
            if (issue_valid && issue_ready) begin
                check_issue(cyc + 1);
            end
            acc = prv_valid && prv_ready;
            if (first_pending && prv_valid) begin
                if (!prv_ready) begin
                    other_errs++;
                    $display("First bundle after reset was not accepted on its first cycle");
                end
                first_pending = 1'b0;
            end
            if (prv_valid && !prv_ready && (cyc % 100) >= 70) begin
                saw_drop = 1'b1;
            end
            if (acc) begin
                push_bundle(cur_b, cyc + 1);
            end
            finished = (bi == total) && (!prv_valid || acc)
                       && (alu_exp.size() == 0) && (mem_exp.size() == 0);
        end

        repeat (8) begin
            @(negedge clk);
            if (issue_valid) begin
                other_errs++;
                $display("Issue port still valid after every expected micro-op issued");
            end
        end
        if (!saw_drop) begin
            other_errs++;
            $display("prv_ready never dropped during an issue stall");
        end
        check_count("perf_alu_dispatched", perf_alu_dispatched, perf_count_t'(n_alu));
        check_count("perf_mem_dispatched", perf_mem_dispatched, perf_count_t'(n_mem));

        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        int waited;
        waited = 0;
        @(posedge clk);                     // Limit is known by now
        while (waited < cycle_limit) begin
            @(posedge clk);
            waited++;
        end
        $display("Timeout after %0d cycles with %0d value mismatches and %0d other failures",
                 waited, value_errs, other_errs);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam real HALF_PERIOD  = 2.0;     // 4 ns clock
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset released on the tenth rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* uop_pkg.sv */
`include "dispatch_settings.svh"

package uop_pkg;

    typedef logic [`REG_BITS-1:0] preg_t;

    // Target station of a renamed micro-op
    typedef enum logic [1:0] {
        RS_NONE = 2'b00,
        RS_ALU  = 2'b01,
        RS_MEM  = 2'b10
    } rs_class_t;

    // Integer ALU payload, 30 bits
    typedef struct packed {
        logic [3:0]     op;
        preg_t          dst;
        preg_t          src1;
        preg_t          src2;
        logic [7:0]     imm;
    } alu_uop_t;

    // Load/store payload, 30 bits
    typedef struct packed {
        logic           is_store;
        logic [2:0]     size;           // Log2 of access bytes
        preg_t          dst;            // Unused by stores
        preg_t          base;
        logic [13:0]    offset;
    } mem_uop_t;

    // One rename slot
    // Only the field selected by rs_class carries meaning
    typedef struct packed {
        rs_class_t      rs_class;
        alu_uop_t       alu;
        mem_uop_t       mem;
    } uop_t;

endpackage
